// File: common/selftest_pkg.sv
// counter and phase types of the tlb self-test harness
`default_nettype none

`include "tlb_selftest_settings.svh"

package selftest_pkg;

    typedef logic [$clog2(`TLB_SEARCH_VECTORS)-1:0] search_id_t;

    // pass and fail are final until the next reset
    typedef enum logic [1:0] {
        PH_WRITE,
        PH_VERIFY,
        PH_PASS,
        PH_FAIL
    } selftest_phase_t;

endpackage

`default_nettype wire

// File: common/tlb_pkg.sv
// field types of a mips-style tlb entry and its index
`default_nettype none

`include "tlb_selftest_settings.svh"

package tlb_pkg;

    // one vpn2 covers an even and an odd page
    typedef logic [18:0] vpn2_t;
    typedef logic [7:0]  asid_t;
    typedef logic [19:0] pfn_t;
    typedef logic [2:0]  cache_attr_t;

    typedef logic [$clog2(`TLB_ENTRIES)-1:0] tlb_index_t;

endpackage

`default_nettype wire

// File: common/tlb_selftest_settings.svh
// tlb self-test sizes, step intervals and final step values
`ifndef TLB_SELFTEST_SETTINGS_SVH
`define TLB_SELFTEST_SETTINGS_SVH

// number of entries in the tlb
`define TLB_ENTRIES 16

// clock cycles between steps on the board and in simulation
`define TLB_STEP_BOARD 30000000
`define TLB_STEP_SIM 5

// number of search vectors, run two per step
`define TLB_SEARCH_VECTORS 26

// counter values of the last read and the last search step
`define TLB_READ_LAST 15
`define TLB_SEARCH_LAST 12

`endif

// File: rtl/selftest_checker.sv
// self-test checker comparing tlb read-back and search results with the patterns
`timescale 1ns/1ps
`default_nettype none

module selftest_checker
    import tlb_pkg::*;
(
    // expected and read-back entry
    input  vpn2_t       e_vpn2, r_vpn2,
    input  asid_t       e_asid, r_asid,
    input  logic        e_g, r_g,
    input  pfn_t        e_pfn0, r_pfn0,
    input  cache_attr_t e_c0, r_c0,
    input  logic        e_d0, r_d0,
    input  logic        e_v0, r_v0,
    input  pfn_t        e_pfn1, r_pfn1,
    input  cache_attr_t e_c1, r_c1,
    input  logic        e_d1, r_d1,
    input  logic        e_v1, r_v1,
    // expected and actual search results
    input  logic        x0_found, s0_found, x1_found, s1_found,
    input  tlb_index_t  x0_index, s0_index, x1_index, s1_index,
    input  pfn_t        x0_pfn, s0_pfn, x1_pfn, s1_pfn,
    input  cache_attr_t x0_c, s0_c, x1_c, s1_c,
    input  logic        x0_d, s0_d, x1_d, s1_d,
    input  logic        x0_v, s0_v, x1_v, s1_v,
    output logic        r_error,
    output logic        s0_error,
    output logic        s1_error
);

    // the page fields of a miss carry no meaning, so only found is compared
    function automatic logic search_mismatch(
        input logic        exp_found,
        input tlb_index_t  exp_index,
        input pfn_t        exp_pfn,
        input cache_attr_t exp_c,
        input logic        exp_d,
        input logic        exp_v,
        input logic        got_found,
        input tlb_index_t  got_index,
        input pfn_t        got_pfn,
        input cache_attr_t got_c,
        input logic        got_d,
        input logic        got_v
    );
        return (exp_found != got_found)
            || (exp_found && (exp_index != got_index || exp_pfn != got_pfn
                              || exp_c != got_c || exp_d != got_d || exp_v != got_v));
    endfunction

    assign r_error = (r_vpn2 != e_vpn2) || (r_asid != e_asid) || (r_g != e_g)
                  || (r_pfn0 != e_pfn0) || (r_c0 != e_c0) || (r_d0 != e_d0) || (r_v0 != e_v0)
                  || (r_pfn1 != e_pfn1) || (r_c1 != e_c1) || (r_d1 != e_d1) || (r_v1 != e_v1);

    assign s0_error = search_mismatch(x0_found, x0_index, x0_pfn, x0_c, x0_d, x0_v,
                                      s0_found, s0_index, s0_pfn, s0_c, s0_d, s0_v);

    assign s1_error = search_mismatch(x1_found, x1_index, x1_pfn, x1_c, x1_d, x1_v,
                                      s1_found, s1_index, s1_pfn, s1_c, s1_d, s1_v);

endmodule

`default_nettype wire

// File: rtl/selftest_patterns.sv
// self-test pattern tables for the written entries and the search vectors
`timescale 1ns/1ps
`default_nettype none

module selftest_patterns
    import tlb_pkg::*;
    import selftest_pkg::*;
(
    input  tlb_index_t  w_cnt,
    input  tlb_index_t  r_cnt,
    input  tlb_index_t  s_cnt,
    // entry for the write port
    output vpn2_t       w_vpn2,
    output asid_t       w_asid,
    output logic        w_g,
    output pfn_t        w_pfn0, w_pfn1,
    output cache_attr_t w_c0, w_c1,
    output logic        w_d0, w_v0, w_d1, w_v1,
    // expected read-back entry
    output vpn2_t       e_vpn2,
    output asid_t       e_asid,
    output logic        e_g,
    output pfn_t        e_pfn0, e_pfn1,
    output cache_attr_t e_c0, e_c1,
    output logic        e_d0, e_v0, e_d1, e_v1,
    // search vectors
    output vpn2_t       s0_vpn2, s1_vpn2,
    output logic        s0_odd_page, s1_odd_page,
    output asid_t       s0_asid, s1_asid,
    // expected search results
    output logic        x0_found, x1_found,
    output tlb_index_t  x0_index, x1_index,
    output pfn_t        x0_pfn, x1_pfn,
    output cache_attr_t x0_c, x1_c,
    output logic        x0_d, x0_v, x1_d, x1_v
);

    localparam int entry_w = $bits(vpn2_t) + $bits(asid_t) + 1
                           + 2 * ($bits(pfn_t) + $bits(cache_attr_t) + 2);
    localparam int search_w = $bits(vpn2_t) + 1 + $bits(asid_t) + 1 + $bits(tlb_index_t)
                            + $bits(pfn_t) + $bits(cache_attr_t) + 2;

    search_id_t s0_id;
    search_id_t s1_id;

    // entry table; pfn keys wrap in four bits so entry 15 maps pfn0 to zero
    function automatic logic [entry_w-1:0] entry_row(input tlb_index_t idx);
        tlb_index_t vpn_key;
        tlb_index_t pfn0_key;
        tlb_index_t pfn1_key;
        vpn2_t      vpn2;
        pfn_t       pfn0;
        pfn_t       pfn1;
        logic       g;
        // entries 5 and 7 repeat the vpn2 of the entry below them
        vpn_key  = (idx == 4'd5 || idx == 4'd7) ? idx - 4'd1 : idx;
        pfn0_key = idx + 4'd1;
        pfn1_key = idx + 4'd2;
        vpn2     = vpn_key * 19'h111;
        pfn0     = pfn0_key * 20'h111;
        pfn1     = pfn1_key * 20'h011;
        g        = (idx == 4'd1) || (idx == 4'd3);
        return {vpn2, asid_t'(idx), g, pfn0, 3'd3, 1'b1, 1'b1,
                pfn1, 3'd3, 1'b1, 1'b1};
    endfunction

    // vpn2, odd_page, asid, then found, index, pfn, c, d, v
    function automatic logic [search_w-1:0] search_row(input search_id_t id);
        case (id)
            5'd0:    return {19'h000, 1'b0, 8'h00, 1'b1, 4'd0,  20'h111, 3'd3, 1'b1, 1'b1};
            5'd1:    return {19'h000, 1'b1, 8'h00, 1'b1, 4'd0,  20'h022, 3'd3, 1'b1, 1'b1};
            5'd2:    return {19'h000, 1'b1, 8'h01, 1'b0, 4'd0,  20'h000, 3'd0, 1'b0, 1'b0};
            5'd3:    return {19'h111, 1'b1, 8'h00, 1'b1, 4'd1,  20'h033, 3'd3, 1'b1, 1'b1};
            5'd4:    return {19'h111, 1'b0, 8'h01, 1'b1, 4'd1,  20'h222, 3'd3, 1'b1, 1'b1};
            5'd5:    return {19'h222, 1'b0, 8'h00, 1'b0, 4'd0,  20'h000, 3'd0, 1'b0, 1'b0};
            5'd6:    return {19'h222, 1'b0, 8'h02, 1'b1, 4'd2,  20'h333, 3'd3, 1'b1, 1'b1};
            5'd7:    return {19'h333, 1'b0, 8'h03, 1'b1, 4'd3,  20'h444, 3'd3, 1'b1, 1'b1};
            5'd8:    return {19'h333, 1'b1, 8'h04, 1'b1, 4'd3,  20'h055, 3'd3, 1'b1, 1'b1};
            5'd9:    return {19'h444, 1'b0, 8'h04, 1'b1, 4'd4,  20'h555, 3'd3, 1'b1, 1'b1};
            5'd10:   return {19'h444, 1'b0, 8'h05, 1'b1, 4'd5,  20'h666, 3'd3, 1'b1, 1'b1};
            5'd11:   return {19'h555, 1'b1, 8'h05, 1'b0, 4'd0,  20'h000, 3'd0, 1'b0, 1'b0};
            5'd12:   return {19'h666, 1'b0, 8'h06, 1'b1, 4'd6,  20'h777, 3'd3, 1'b1, 1'b1};
            5'd13:   return {19'h666, 1'b1, 8'h07, 1'b1, 4'd7,  20'h099, 3'd3, 1'b1, 1'b1};
            5'd14:   return {19'h666, 1'b1, 8'h08, 1'b0, 4'd0,  20'h000, 3'd0, 1'b0, 1'b0};
            5'd15:   return {19'h777, 1'b0, 8'h07, 1'b0, 4'd0,  20'h000, 3'd0, 1'b0, 1'b0};
            5'd16:   return {19'h888, 1'b0, 8'h08, 1'b1, 4'd8,  20'h999, 3'd3, 1'b1, 1'b1};
            5'd17:   return {19'h999, 1'b1, 8'h09, 1'b1, 4'd9,  20'h0bb, 3'd3, 1'b1, 1'b1};
            5'd18:   return {19'haaa, 1'b0, 8'h0a, 1'b1, 4'd10, 20'hbbb, 3'd3, 1'b1, 1'b1};
            5'd19:   return {19'hbbb, 1'b1, 8'h0b, 1'b1, 4'd11, 20'h0dd, 3'd3, 1'b1, 1'b1};
            5'd20:   return {19'hccc, 1'b0, 8'h0c, 1'b1, 4'd12, 20'hddd, 3'd3, 1'b1, 1'b1};
            5'd21:   return {19'hddd, 1'b1, 8'h0d, 1'b1, 4'd13, 20'h0ff, 3'd3, 1'b1, 1'b1};
            5'd22:   return {19'heee, 1'b0, 8'h0e, 1'b1, 4'd14, 20'hfff, 3'd3, 1'b1, 1'b1};
            5'd23:   return {19'hfff, 1'b1, 8'h0f, 1'b1, 4'd15, 20'h011, 3'd3, 1'b1, 1'b1};
            5'd24:   return {19'habc, 1'b0, 8'h0f, 1'b0, 4'd0,  20'h000, 3'd0, 1'b0, 1'b0};
            5'd25:   return {19'h123, 1'b1, 8'h03, 1'b0, 4'd0,  20'h000, 3'd0, 1'b0, 1'b0};
            default: return '0;
        endcase
    endfunction

    // each search step runs an even and an odd vector side by side
    assign s0_id = {s_cnt, 1'b0};
    assign s1_id = {s_cnt, 1'b1};

    assign {w_vpn2, w_asid, w_g, w_pfn0, w_c0, w_d0, w_v0,
            w_pfn1, w_c1, w_d1, w_v1} = entry_row(w_cnt);

    assign {e_vpn2, e_asid, e_g, e_pfn0, e_c0, e_d0, e_v0,
            e_pfn1, e_c1, e_d1, e_v1} = entry_row(r_cnt);

    assign {s0_vpn2, s0_odd_page, s0_asid, x0_found, x0_index,
            x0_pfn, x0_c, x0_d, x0_v} = search_row(s0_id);

    assign {s1_vpn2, s1_odd_page, s1_asid, x1_found, x1_index,
            x1_pfn, x1_c, x1_d, x1_v} = search_row(s1_id);

endmodule

`default_nettype wire

// File: rtl/selftest_sequencer.sv
// self-test sequencer with the step counters, the phase FSM and the status lights
`timescale 1ns/1ps
`default_nettype none

`include "tlb_selftest_settings.svh"

module selftest_sequencer
    import tlb_pkg::*;
    import selftest_pkg::*;
(
    input  logic       clk_g,
    input  logic       resetn,
    input  logic       step,
    input  logic       r_error,
    input  logic       s0_error,
    input  logic       s1_error,
    output logic       we,
    output tlb_index_t w_cnt,
    output tlb_index_t r_cnt,
    output tlb_index_t s_cnt,
    output logic [3:0] led_n
);

    localparam tlb_index_t write_last  = tlb_index_t'(`TLB_ENTRIES - 1);
    localparam tlb_index_t read_last   = tlb_index_t'(`TLB_READ_LAST);
    localparam tlb_index_t search_last = tlb_index_t'(`TLB_SEARCH_LAST);

    selftest_phase_t state;
    logic            read_ok;
    logic            search_ok;
    logic            verifying;
    logic            search_error;

    assign verifying    = (state == PH_VERIFY);
    assign search_error = s0_error || s1_error;

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            state <= PH_WRITE;
        end else begin
            case (state)
                PH_WRITE: begin
                    // the last entry is written at the same edge
                    if (w_cnt == write_last) begin
                        state <= PH_VERIFY;
                    end
                end
                PH_VERIFY: begin
                    if ((!read_ok && r_error) || (!search_ok && search_error)) begin
                        state <= PH_FAIL;
                    end else if (read_ok && search_ok) begin
                        state <= PH_PASS;
                    end
                end
                default: begin
                    state <= state;
                end
            endcase
        end
    end

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            w_cnt <= '0;
        end else if (state == PH_WRITE && step && w_cnt != write_last) begin
            w_cnt <= w_cnt + 1'b1;
        end
    end

    // read-back and search run side by side once all entries are written
    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            r_cnt   <= '0;
            read_ok <= 1'b0;
        end else if (verifying && !read_ok && !r_error) begin
            if (r_cnt == read_last) begin
                read_ok <= 1'b1;
            end else if (step) begin
                r_cnt <= r_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            s_cnt     <= '0;
            search_ok <= 1'b0;
        end else if (verifying && !search_ok && !search_error) begin
            if (s_cnt == search_last) begin
                search_ok <= 1'b1;
            end else if (step) begin
                s_cnt <= s_cnt + 1'b1;
            end
        end
    end

    assign we = (state == PH_WRITE);

    // lights are active low, in the order error, write, read, search
    assign led_n = {state != PH_FAIL, state == PH_WRITE, !read_ok, !search_ok};

endmodule

`default_nettype wire

// File: rtl/step_timer.sv
// step timer that pulses once every step_cycles+1 clock cycles
`timescale 1ns/1ps
`default_nettype none

`include "tlb_selftest_settings.svh"

module step_timer #(
    parameter int unsigned step_cycles = `TLB_STEP_BOARD
) (
    input  logic clk_g,
    input  logic resetn,
    output logic step
);

    localparam int unsigned cnt_w = (step_cycles > 0) ? $clog2(step_cycles + 1) : 1;

    logic [cnt_w-1:0] count;

    // the counter reloads in the same cycle that step is high
    always_ff @(posedge clk_g) begin
        if (!resetn || step) begin
            count <= cnt_w'(step_cycles);
        end else begin
            count <= count - 1'b1;
        end
    end

    assign step = (count == '0);

endmodule

`default_nettype wire

// File: rtl/tlb_selftest_top.sv
// board top of the tlb self-test, joining timer, sequencer, patterns, checker and tlb
`timescale 1ns/1ps
`default_nettype none

`include "tlb_selftest_settings.svh"

module tlb_selftest_top
    import tlb_pkg::*;
#(
    parameter int unsigned step_cycles = `TLB_STEP_BOARD
) (
    input  logic       clk_g,
    input  logic       resetn,
    output logic [3:0] led_n,
    output tlb_index_t w_cnt,
    output tlb_index_t r_cnt,
    output tlb_index_t s_cnt
);

    logic step;
    logic we;
    logic r_error;
    logic s0_error;
    logic s1_error;

    // written entry, expected entry and read-back entry
    vpn2_t       w_vpn2, e_vpn2, r_vpn2;
    asid_t       w_asid, e_asid, r_asid;
    logic        w_g, e_g, r_g;
    pfn_t        w_pfn0, e_pfn0, r_pfn0;
    cache_attr_t w_c0, e_c0, r_c0;
    logic        w_d0, e_d0, r_d0;
    logic        w_v0, e_v0, r_v0;
    pfn_t        w_pfn1, e_pfn1, r_pfn1;
    cache_attr_t w_c1, e_c1, r_c1;
    logic        w_d1, e_d1, r_d1;
    logic        w_v1, e_v1, r_v1;

    // search vectors, expected results and tlb results
    vpn2_t       s0_vpn2, s1_vpn2;
    logic        s0_odd_page, s1_odd_page;
    asid_t       s0_asid, s1_asid;
    logic        x0_found, x1_found, s0_found, s1_found;
    tlb_index_t  x0_index, x1_index, s0_index, s1_index;
    pfn_t        x0_pfn, x1_pfn, s0_pfn, s1_pfn;
    cache_attr_t x0_c, x1_c, s0_c, s1_c;
    logic        x0_d, x1_d, s0_d, s1_d;
    logic        x0_v, x1_v, s0_v, s1_v;

    step_timer #(.step_cycles(step_cycles)) step_timer_inst (.*);

    selftest_sequencer selftest_sequencer_inst (.*);

    selftest_patterns selftest_patterns_inst (.*);

    selftest_checker selftest_checker_inst (.*);

    // the write and read counters address the entry store directly
    tlb tlb_inst (
        .w_index (w_cnt),
        .r_index (r_cnt),
        .*
    );

endmodule

`default_nettype wire

// File: src.f
+incdir+common
common/tlb_pkg.sv
common/selftest_pkg.sv
tlb/tlb_search.sv
tlb/tlb.sv
rtl/step_timer.sv
rtl/selftest_patterns.sv
rtl/selftest_checker.sv
rtl/selftest_sequencer.sv
rtl/tlb_selftest_top.sv
test/tb_tlb_selftest.sv

// File: test/tb_tlb_selftest.sv
// testbench for the tlb self-test, checking harness outputs and tlb results against a reference
`timescale 1ns/1ps
`default_nettype none

`include "tlb_selftest_settings.svh"

module tb_tlb_selftest
    import tlb_pkg::*;
();

    localparam int clk_half     = 20;
    localparam int reset_cycles = 10;
    localparam int period       = `TLB_STEP_SIM + 1;
    localparam int entry_last   = `TLB_ENTRIES - 1;
    // edge counts out of reset after which each phase has completed
    localparam int write_end    = entry_last * period + 1;
    localparam int search_end   = (entry_last + `TLB_SEARCH_LAST) * period + 1;
    localparam int read_end     = (entry_last + `TLB_READ_LAST) * period + 1;
    localparam int final_end    = read_end + 5 * period;
    localparam int watchdog_cycles = reset_cycles + 40 * period;
    localparam int test_count   = 5;

    logic       clk_g;
    logic       resetn;
    logic [3:0] led_n;
    tlb_index_t w_cnt;
    tlb_index_t r_cnt;
    tlb_index_t s_cnt;

    int    edges = 0;
    int    test_errors [test_count];
    string test_names [test_count] = '{"reset state", "write phase", "read-back",
                                       "search", "final state"};

    tlb_selftest_top #(.step_cycles(`TLB_STEP_SIM)) tlb_selftest_top_inst (.*);

    initial begin
        clk_g = 1'b0;
        forever #(clk_half) clk_g = ~clk_g;
    end

    // clock edges seen by the design since reset was released
    always @(posedge clk_g) begin
        if (resetn) begin
            edges <= edges + 1;
        end
    end

    function automatic int limit_to(input int value, input int limit);
        return (value > limit) ? limit : value;
    endfunction

    // entries 5 and 7 alias the virtual pages of entries 4 and 6
    function automatic logic [18:0] ref_vpn2(input int idx);
        case (idx)
            5:       return 19'h444;
            7:       return 19'h666;
            default: return 19'(idx * 'h111);
        endcase
    endfunction

    function automatic logic ref_global(input int idx);
        return (idx == 1) || (idx == 3);
    endfunction

    // frame keys wrap at the entry count, so entry 15 maps its even page to frame 0
    function automatic logic [19:0] ref_pfn(input int idx, input logic odd);
        if (odd) begin
            return 20'(((idx + 2) % `TLB_ENTRIES) * 'h011);
        end else begin
            return 20'(((idx + 1) % `TLB_ENTRIES) * 'h111);
        end
    endfunction

    // search vector as {vpn2, odd_page, asid}
    function automatic logic [27:0] search_vector(input int id);
        case (id)
            0:       return {19'h000, 1'b0, 8'h00};
            1:       return {19'h000, 1'b1, 8'h00};
            2:       return {19'h000, 1'b1, 8'h01};
            3:       return {19'h111, 1'b1, 8'h00};
            4:       return {19'h111, 1'b0, 8'h01};
            5:       return {19'h222, 1'b0, 8'h00};
            6:       return {19'h222, 1'b0, 8'h02};
            7:       return {19'h333, 1'b0, 8'h03};
            8:       return {19'h333, 1'b1, 8'h04};
            9:       return {19'h444, 1'b0, 8'h04};
            10:      return {19'h444, 1'b0, 8'h05};
            11:      return {19'h555, 1'b1, 8'h05};
            12:      return {19'h666, 1'b0, 8'h06};
            13:      return {19'h666, 1'b1, 8'h07};
            14:      return {19'h666, 1'b1, 8'h08};
            15:      return {19'h777, 1'b0, 8'h07};
            16:      return {19'h888, 1'b0, 8'h08};
            17:      return {19'h999, 1'b1, 8'h09};
            18:      return {19'haaa, 1'b0, 8'h0a};
            19:      return {19'hbbb, 1'b1, 8'h0b};
            20:      return {19'hccc, 1'b0, 8'h0c};
            21:      return {19'hddd, 1'b1, 8'h0d};
            22:      return {19'heee, 1'b0, 8'h0e};
            23:      return {19'hfff, 1'b1, 8'h0f};
            24:      return {19'habc, 1'b0, 8'h0f};
            25:      return {19'h123, 1'b1, 8'h03};
            default: return '0;
        endcase
    endfunction

    function automatic void search_reference(input int id, output logic found,
                                             output int index, output logic [19:0] pfn);
        logic [18:0] vpn2;
        logic        odd;
        logic [7:0]  asid;
        {vpn2, odd, asid} = search_vector(id);
        found = 1'b0;
        index = 0;
        pfn   = '0;
        // walking up from entry 0, the first match is the lowest one
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (!found && ref_vpn2(i) == vpn2 && (ref_global(i) || asid == 8'(i))) begin
                found = 1'b1;
                index = i;
                pfn   = ref_pfn(i, odd);
            end
        end
    endfunction

    // expected {led_n, w_cnt, r_cnt, s_cnt} after a number of edges out of reset
    function automatic logic [15:0] expected_outputs(input int count);
        int   steps;
        int   verify_steps;
        logic write_done;
        steps        = count / period;
        write_done   = count >= write_end;
        // read-back and search start with the first step after the last write
        verify_steps = write_done ? steps - entry_last : 0;
        return {1'b1, !write_done, !(count >= read_end), !(count >= search_end),
                4'(limit_to(steps, entry_last)),
                4'(limit_to(verify_steps, `TLB_READ_LAST)),
                4'(limit_to(verify_steps, `TLB_SEARCH_LAST))};
    endfunction

    task automatic report_mismatch(input int id, input string name,
                                   input logic [31:0] got, input logic [31:0] expected);
        $display("MISMATCH time=%0t signal=%s got=%0h expected=%0h", $time, name, got, expected);
        test_errors[id]++;
    endtask

    task automatic check_search(input int id, input int port, input int vec);
        logic        exp_found;
        int          exp_index;
        logic [19:0] exp_pfn;
        logic        got_found;
        logic [3:0]  got_index;
        logic [19:0] got_pfn;
        search_reference(vec, exp_found, exp_index, exp_pfn);
        got_found = port ? tlb_selftest_top_inst.s1_found : tlb_selftest_top_inst.s0_found;
        got_index = port ? tlb_selftest_top_inst.s1_index : tlb_selftest_top_inst.s0_index;
        got_pfn   = port ? tlb_selftest_top_inst.s1_pfn : tlb_selftest_top_inst.s0_pfn;
        if (got_found !== exp_found) begin
            report_mismatch(id, $sformatf("s%0d_found", port), got_found, exp_found);
        end
        if (exp_found && got_index !== 4'(exp_index)) begin
            report_mismatch(id, $sformatf("s%0d_index", port), got_index, exp_index);
        end
        if (exp_found && got_pfn !== exp_pfn) begin
            report_mismatch(id, $sformatf("s%0d_pfn", port), got_pfn, exp_pfn);
        end
    endtask

    task automatic check_cycle(input int id);
        logic [3:0] exp_led;
        tlb_index_t exp_w;
        tlb_index_t exp_r;
        tlb_index_t exp_s;
        {exp_led, exp_w, exp_r, exp_s} = expected_outputs(edges);
        case (id)
            2: begin
                if (led_n[3] !== 1'b1) report_mismatch(id, "led_n[3]", led_n[3], 1'b1);
                if (led_n[1] !== exp_led[1]) report_mismatch(id, "led_n[1]", led_n[1], exp_led[1]);
                if (w_cnt !== exp_w) report_mismatch(id, "w_cnt", w_cnt, exp_w);
                if (r_cnt !== exp_r) report_mismatch(id, "r_cnt", r_cnt, exp_r);
                if (tlb_selftest_top_inst.r_vpn2 !== ref_vpn2(exp_r)) begin
                    report_mismatch(id, "r_vpn2", tlb_selftest_top_inst.r_vpn2, ref_vpn2(exp_r));
                end
                if (tlb_selftest_top_inst.r_asid !== 8'(exp_r)) begin
                    report_mismatch(id, "r_asid", tlb_selftest_top_inst.r_asid, exp_r);
                end
                if (tlb_selftest_top_inst.r_g !== ref_global(exp_r)) begin
                    report_mismatch(id, "r_g", tlb_selftest_top_inst.r_g, ref_global(exp_r));
                end
                if (tlb_selftest_top_inst.r_pfn0 !== ref_pfn(exp_r, 1'b0)) begin
                    report_mismatch(id, "r_pfn0", tlb_selftest_top_inst.r_pfn0,
                                    ref_pfn(exp_r, 1'b0));
                end
                if (tlb_selftest_top_inst.r_pfn1 !== ref_pfn(exp_r, 1'b1)) begin
                    report_mismatch(id, "r_pfn1", tlb_selftest_top_inst.r_pfn1,
                                    ref_pfn(exp_r, 1'b1));
                end
            end
            3: begin
                if (led_n[0] !== exp_led[0]) report_mismatch(id, "led_n[0]", led_n[0], exp_led[0]);
                if (s_cnt !== exp_s) report_mismatch(id, "s_cnt", s_cnt, exp_s);
                check_search(id, 0, 2 * int'(exp_s));
                check_search(id, 1, 2 * int'(exp_s) + 1);
            end
            default: begin
                if (led_n !== exp_led) report_mismatch(id, "led_n", led_n, exp_led);
                if (w_cnt !== exp_w) report_mismatch(id, "w_cnt", w_cnt, exp_w);
                if (r_cnt !== exp_r) report_mismatch(id, "r_cnt", r_cnt, exp_r);
                if (s_cnt !== exp_s) report_mismatch(id, "s_cnt", s_cnt, exp_s);
            end
        endcase
    endtask

    // checks every cycle up to the last edge count of the test, sampling on falling edges
    task automatic run_test(input int id, input int last);
        while (edges <= last) begin
            check_cycle(id);
            @(negedge clk_g);
        end
        if (test_errors[id] == 0) begin
            $display("test %0d %s: ok", id + 1, test_names[id]);
        end else begin
            $display("test %0d %s: %0d mismatches", id + 1, test_names[id], test_errors[id]);
        end
    endtask

    initial begin : main_sequence
        int failed;
        int mismatches;
        failed     = 0;
        mismatches = 0;
        resetn     = 1'b0;
        repeat (reset_cycles) @(posedge clk_g);
        resetn <= 1'b1;
        @(negedge clk_g);
        run_test(0, period - 1);
        run_test(1, write_end);
        fork
            run_test(2, read_end);
            run_test(3, search_end);
        join
        run_test(4, final_end);
        for (int i = 0; i < test_count; i++) begin
            mismatches += test_errors[i];
            if (test_errors[i] != 0) begin
                failed++;
            end
        end
        $display("%0d tests run, %0d passed, %0d failed, %0d mismatches",
                 test_count, test_count - failed, failed, mismatches);
        if (failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin : watchdog
        #(watchdog_cycles * 2 * clk_half);
        $display("timeout: the self-test did not finish within %0d cycles", watchdog_cycles);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: tlb/tlb.sv
// dual-search tlb entry store with one write port and one read port
`timescale 1ns/1ps
`default_nettype none

`include "tlb_selftest_settings.svh"

module tlb
    import tlb_pkg::*;
(
    input  logic        clk_g,
    // write port
    input  logic        we,
    input  tlb_index_t  w_index,
    input  vpn2_t       w_vpn2,
    input  asid_t       w_asid,
    input  logic        w_g,
    input  pfn_t        w_pfn0, w_pfn1,
    input  cache_attr_t w_c0, w_c1,
    input  logic        w_d0, w_v0, w_d1, w_v1,
    // read port
    input  tlb_index_t  r_index,
    output vpn2_t       r_vpn2,
    output asid_t       r_asid,
    output logic        r_g,
    output pfn_t        r_pfn0, r_pfn1,
    output cache_attr_t r_c0, r_c1,
    output logic        r_d0, r_v0, r_d1, r_v1,
    // search port 0
    input  vpn2_t       s0_vpn2,
    input  logic        s0_odd_page,
    input  asid_t       s0_asid,
    output logic        s0_found,
    output tlb_index_t  s0_index,
    output pfn_t        s0_pfn,
    output cache_attr_t s0_c,
    output logic        s0_d, s0_v,
    // search port 1
    input  vpn2_t       s1_vpn2,
    input  logic        s1_odd_page,
    input  asid_t       s1_asid,
    output logic        s1_found,
    output tlb_index_t  s1_index,
    output pfn_t        s1_pfn,
    output cache_attr_t s1_c,
    output logic        s1_d, s1_v
);

    vpn2_t       ent_vpn2 [`TLB_ENTRIES];
    asid_t       ent_asid [`TLB_ENTRIES];
    logic        ent_g    [`TLB_ENTRIES];
    pfn_t        ent_pfn0 [`TLB_ENTRIES];
    cache_attr_t ent_c0   [`TLB_ENTRIES];
    logic        ent_d0   [`TLB_ENTRIES];
    logic        ent_v0   [`TLB_ENTRIES];
    pfn_t        ent_pfn1 [`TLB_ENTRIES];
    cache_attr_t ent_c1   [`TLB_ENTRIES];
    logic        ent_d1   [`TLB_ENTRIES];
    logic        ent_v1   [`TLB_ENTRIES];

    always_ff @(posedge clk_g) begin
        if (we) begin
            ent_vpn2[w_index] <= w_vpn2;
            ent_asid[w_index] <= w_asid;
            ent_g[w_index]    <= w_g;
            ent_pfn0[w_index] <= w_pfn0;
            ent_c0[w_index]   <= w_c0;
            ent_d0[w_index]   <= w_d0;
            ent_v0[w_index]   <= w_v0;
            ent_pfn1[w_index] <= w_pfn1;
            ent_c1[w_index]   <= w_c1;
            ent_d1[w_index]   <= w_d1;
            ent_v1[w_index]   <= w_v1;
        end
    end

    assign r_vpn2 = ent_vpn2[r_index];
    assign r_asid = ent_asid[r_index];
    assign r_g    = ent_g[r_index];
    assign r_pfn0 = ent_pfn0[r_index];
    assign r_c0   = ent_c0[r_index];
    assign r_d0   = ent_d0[r_index];
    assign r_v0   = ent_v0[r_index];
    assign r_pfn1 = ent_pfn1[r_index];
    assign r_c1   = ent_c1[r_index];
    assign r_d1   = ent_d1[r_index];
    assign r_v1   = ent_v1[r_index];

    // both search units see every entry, the ent_* arrays connect by name
    tlb_search search0_inst (
        .vpn2     (s0_vpn2),
        .odd_page (s0_odd_page),
        .asid     (s0_asid),
        .found    (s0_found),
        .index    (s0_index),
        .pfn      (s0_pfn),
        .c        (s0_c),
        .d        (s0_d),
        .v        (s0_v),
        .*
    );

    tlb_search search1_inst (
        .vpn2     (s1_vpn2),
        .odd_page (s1_odd_page),
        .asid     (s1_asid),
        .found    (s1_found),
        .index    (s1_index),
        .pfn      (s1_pfn),
        .c        (s1_c),
        .d        (s1_d),
        .v        (s1_v),
        .*
    );

endmodule

`default_nettype wire

// File: tlb/tlb_search.sv
// tlb search unit that matches all entries and returns one page of the lowest hit
`timescale 1ns/1ps
`default_nettype none

`include "tlb_selftest_settings.svh"

module tlb_search
    import tlb_pkg::*;
(
    input  vpn2_t       ent_vpn2 [`TLB_ENTRIES],
    input  asid_t       ent_asid [`TLB_ENTRIES],
    input  logic        ent_g    [`TLB_ENTRIES],
    input  pfn_t        ent_pfn0 [`TLB_ENTRIES],
    input  cache_attr_t ent_c0   [`TLB_ENTRIES],
    input  logic        ent_d0   [`TLB_ENTRIES],
    input  logic        ent_v0   [`TLB_ENTRIES],
    input  pfn_t        ent_pfn1 [`TLB_ENTRIES],
    input  cache_attr_t ent_c1   [`TLB_ENTRIES],
    input  logic        ent_d1   [`TLB_ENTRIES],
    input  logic        ent_v1   [`TLB_ENTRIES],
    input  vpn2_t       vpn2,
    input  logic        odd_page,
    input  asid_t       asid,
    output logic        found,
    output tlb_index_t  index,
    output pfn_t        pfn,
    output cache_attr_t c,
    output logic        d,
    output logic        v
);

    logic [`TLB_ENTRIES-1:0] match;

    // a global entry matches under any asid
    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            match[i] = (ent_vpn2[i] == vpn2) && (ent_g[i] || ent_asid[i] == asid);
        end
    end

    // scanning downwards leaves the lowest matching entry in index
    always_comb begin
        index = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                index = tlb_index_t'(i);
            end
        end
    end

    assign found = |match;
    assign pfn   = odd_page ? ent_pfn1[index] : ent_pfn0[index];
    assign c     = odd_page ? ent_c1[index] : ent_c0[index];
    assign d     = odd_page ? ent_d1[index] : ent_d0[index];
    assign v     = odd_page ? ent_v1[index] : ent_v0[index];

endmodule

`default_nettype wire
